// File: tests/rn_vectors.txt
// op val we cr | lrs1 lrs2 lrd slot0 | lrs1 lrs2 lrd slot1 | exp prs1 prs2 prd pfree slot0, slot1
// commit reuses lrd, prd and pfree columns; cr holds the cycle count for ops 4 and 5
01_03_03_00_01_02_03_04_05_06_01_02_20_03_04_05_21_06
01_03_02_00_03_06_00_07_08_09_20_21_00_00_07_08_22_09
01_03_03_00_01_01_0a_0a_03_0a_01_01_23_0a_23_20_24_23
01_01_01_00_09_0a_0b_00_00_00_22_24_25_0b_00_00_00_00
05_00_00_05_00_00_00_00_00_00_00_00_00_00_00_00_00_00
04_00_00_02_00_00_00_00_00_00_00_00_00_00_00_00_00_00
02_00_03_00_00_00_03_00_00_06_00_00_20_03_00_00_21_06
02_00_02_00_00_00_00_00_00_09_00_00_00_00_00_00_22_09
03_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00_00
01_03_03_00_0a_0b_03_09_06_0c_0a_0b_23_20_22_21_24_0c
01_03_03_02_14_15_14_14_15_15_14_15_25_14_25_15_26_15
01_03_03_02_14_15_14_14_15_15_25_26_27_25_27_26_28_26
01_03_03_02_14_15_14_14_15_15_27_28_29_27_29_28_2a_28
01_03_03_02_14_15_14_14_15_15_29_2a_2b_29_2b_2a_2c_2a
01_03_03_02_14_15_14_14_15_15_2b_2c_2d_2b_2d_2c_2e_2c
01_03_03_02_14_15_14_14_15_15_2d_2e_2f_2d_2f_2e_30_2e
01_03_03_02_14_15_14_14_15_15_2f_30_31_2f_31_30_32_30
01_03_03_02_14_15_14_14_15_15_31_32_33_31_33_32_34_32
01_03_03_02_14_15_14_14_15_15_33_34_35_33_35_34_36_34
01_03_03_02_14_15_14_14_15_15_35_36_37_35_37_36_38_36
01_03_03_02_14_15_14_14_15_15_37_38_39_37_39_38_3a_38
01_03_03_02_14_15_14_14_15_15_39_3a_3b_39_3b_3a_3c_3a
01_03_03_02_14_15_14_14_15_15_3b_3c_3d_3b_3d_3c_3e_3c
01_03_03_02_14_15_14_14_15_15_3d_3e_3f_3d_3f_3e_03_3e
01_03_03_02_14_15_14_14_15_15_3f_03_06_3f_06_03_09_03

// File: project.f
+incdir+src
src/rn_reg_pkg.sv
src/rn_flow_pkg.sv
src/rn_rat.sv
src/rn_free_list.sv
src/rn_credit_ctrl.sv
src/rn_top.sv
tests/rn_checker.sv
tests/tb_rn_top.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module tb_rn_top
	./obj_dir/Vtb_rn_top | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_rn_top.sv
/*
 Testbench for the rename stage, runs the records of tests/rn_vectors.txt
 Records are 18 hex bytes; ops 1 rename, 2 commit, 3 rollback, 4 credit return, 5 ready low
 Run from the project root so the vector path resolves
*/
`default_nettype none

module tb_rn_top;

   localparam int WAIT_LIMIT = 50;
   localparam int NUM_REC    = 64;

   logic          clk;
   logic          arst_n;
   logic [1:0]    rn_valid;
   logic [9:0]    rn_lrs1;
   logic [9:0]    rn_lrs2;
   logic [9:0]    rn_lrd;
   logic [1:0]    rn_lrd_we;
   wire           rn_ready;
   logic [1:0]    commit_we;
   logic [9:0]    commit_lrd;
   logic [11:0]   commit_prd;
   logic [11:0]   commit_pfree;
   logic          rollback;
   wire           out_valid;
   wire  [1:0]    out_slot_valid;
   wire  [11:0]   out_prs1;
   wire  [11:0]   out_prs2;
   wire  [11:0]   out_prd;
   wire  [11:0]   out_pfree;
   logic [1:0]    sch_credit_ret;

   logic [143:0]  vec_mem [NUM_REC];
   logic [31:0]   lfsr;
   int            tb_errors;
   bit            abort;

   rn_top i_dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .rn_valid       (rn_valid),
      .rn_lrs1        (rn_lrs1),
      .rn_lrs2        (rn_lrs2),
      .rn_lrd         (rn_lrd),
      .rn_lrd_we      (rn_lrd_we),
      .rn_ready       (rn_ready),
      .commit_we      (commit_we),
      .commit_lrd     (commit_lrd),
      .commit_prd     (commit_prd),
      .commit_pfree   (commit_pfree),
      .rollback       (rollback),
      .out_valid      (out_valid),
      .out_slot_valid (out_slot_valid),
      .out_prs1       (out_prs1),
      .out_prs2       (out_prs2),
      .out_prd        (out_prd),
      .out_pfree      (out_pfree),
      .sch_credit_ret (sch_credit_ret)
   );

   rn_checker i_chk (
      .clk            (clk),
      .arst_n         (arst_n),
      .out_valid      (out_valid),
      .out_slot_valid (out_slot_valid),
      .out_prs1       (out_prs1),
      .out_prs2       (out_prs2),
      .out_prd        (out_prd),
      .out_pfree      (out_pfree)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   function automatic logic [7:0] rec_byte(input logic [143:0] r, input int i);
      return r[143 - 8*i -: 8];
   endfunction

   // Galois LFSR, taps 32 22 2 1
   function automatic logic take_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      return b;
   endfunction

   task automatic idle_gap();
      logic [1:0] g;
      g[0] = take_bit();
      g[1] = take_bit();
      repeat (g) @(posedge clk);
   endtask

   task automatic rename_group(input logic [143:0] r);
      bit got;
      int n;
      got = 1'b0;
      n = 0;
      @(posedge clk);
      rn_valid  <= 2'(rec_byte(r, 1));
      rn_lrd_we <= 2'(rec_byte(r, 2));
      rn_lrs1   <= {5'(rec_byte(r, 7)), 5'(rec_byte(r, 4))};
      rn_lrs2   <= {5'(rec_byte(r, 8)), 5'(rec_byte(r, 5))};
      rn_lrd    <= {5'(rec_byte(r, 9)), 5'(rec_byte(r, 6))};
      // Ready is stable by the falling edge
      while (!got && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         if (rn_ready)
            got = 1'b1;
         else
            n++;
      end
      if (!got)
      begin
         $display("timeout: rn_ready never rose for a pending group");
         tb_errors++;
         abort = 1'b1;
      end
      else
      begin
         @(posedge clk);
         i_chk.expect_group(r);
         rn_valid       <= 2'b00;
         sch_credit_ret <= 2'(rec_byte(r, 3));
         @(posedge clk);
         sch_credit_ret <= 2'd0;
      end
   endtask

   task automatic commit_group(input logic [143:0] r);
      @(posedge clk);
      commit_we    <= 2'(rec_byte(r, 2));
      commit_lrd   <= {5'(rec_byte(r, 9)), 5'(rec_byte(r, 6))};
      commit_prd   <= {6'(rec_byte(r, 16)), 6'(rec_byte(r, 12))};
      commit_pfree <= {6'(rec_byte(r, 17)), 6'(rec_byte(r, 13))};
      @(posedge clk);
      commit_we    <= 2'b00;
   endtask

   task automatic pulse_rollback();
      @(posedge clk);
      rollback <= 1'b1;
      @(posedge clk);
      rollback <= 1'b0;
   endtask

   // Two credits per cycle for n cycles
   task automatic return_credits(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         sch_credit_ret <= 2'd2;
      end
      @(posedge clk);
      sch_credit_ret <= 2'd0;
   endtask

   task automatic check_ready_low(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         if (rn_ready)
         begin
            $display("rn_ready high while the scheduler has no credits");
            tb_errors++;
         end
      end
   endtask

   task automatic drain_output();
      int n;
      n = 0;
      while (i_chk.pending() != 0 && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (i_chk.pending() != 0)
      begin
         $display("timeout: %0d renamed groups never came out", i_chk.pending());
         tb_errors++;
      end
   endtask

   initial
   begin : main
      int idx;
      logic [7:0] op;
      arst_n         = 1'b0;
      rn_valid       = '0;
      rn_lrs1        = '0;
      rn_lrs2        = '0;
      rn_lrd         = '0;
      rn_lrd_we      = '0;
      commit_we      = '0;
      commit_lrd     = '0;
      commit_prd     = '0;
      commit_pfree   = '0;
      rollback       = 1'b0;
      sch_credit_ret = '0;
      lfsr           = 32'd76327;
      tb_errors      = 0;
      abort          = 1'b0;
      for (int i = 0; i < NUM_REC; i++)
      begin
         vec_mem[i] = '0;
      end
      $readmemh("tests/rn_vectors.txt", vec_mem);
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      idx = 0;
      // An all-zero record ends the list
      while (idx < NUM_REC && !abort && vec_mem[idx] != '0)
      begin
         op = rec_byte(vec_mem[idx], 0);
         case (op)
            8'h01: rename_group(vec_mem[idx]);
            8'h02: commit_group(vec_mem[idx]);
            8'h03: pulse_rollback();
            8'h04: return_credits(int'(rec_byte(vec_mem[idx], 3)));
            8'h05: check_ready_low(int'(rec_byte(vec_mem[idx], 3)));
            default:
            begin
               $display("unknown opcode %h in vector record %0d", op, idx);
               tb_errors++;
            end
         endcase
         idle_gap();
         idx++;
      end
      drain_output();
      $display("mismatches %0d, unexpected outputs %0d, other errors %0d",
               i_chk.mismatch_count, i_chk.other_count, tb_errors);
      if (i_chk.mismatch_count == 0 && i_chk.other_count == 0 && tb_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/rn_checker.sv
/*
 Scoreboard for the rename output, samples on the falling edge
 Expected groups are queued by the testbench at each accept, in order
 prd and pfree are only compared on slots that are valid and write a destination
*/
`default_nettype none

module rn_checker
(
   input  wire          clk,
   input  wire          arst_n,
   input  wire          out_valid,
   input  wire [1:0]    out_slot_valid,
   input  wire [11:0]   out_prs1,
   input  wire [11:0]   out_prs2,
   input  wire [11:0]   out_prd,
   input  wire [11:0]   out_pfree
);
   // One vector record per accepted group
   logic [143:0] exp_q [$];
   int           mismatch_count = 0;
   int           other_count = 0;

   // Byte i of a record, byte 0 is the opcode
   function automatic logic [7:0] rec_byte(input logic [143:0] r, input int i);
      return r[143 - 8*i -: 8];
   endfunction

   task automatic expect_group(input logic [143:0] rec);
      exp_q.push_back(rec);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic compare_preg(input string name, input int slot, input logic [5:0] got,
                               input logic [7:0] want);
      if (got !== want[5:0])
      begin
         $display("mismatch %s[%0d]: got %h expected %h", name, slot, got, want[5:0]);
         mismatch_count++;
      end
   endtask

   always @(negedge clk)
   begin : check_group
      logic [143:0] rec;
      logic [7:0]   val;
      logic [7:0]   we;
      if (arst_n && out_valid)
      begin
         if (exp_q.size() == 0)
         begin
            $display("out_valid seen with no group expected");
            other_count++;
         end
         else
         begin
            rec = exp_q.pop_front();
            val = rec_byte(rec, 1);
            we  = rec_byte(rec, 2);
            if (out_slot_valid !== val[1:0])
            begin
               $display("mismatch out_slot_valid: got %h expected %h", out_slot_valid, val[1:0]);
               mismatch_count++;
            end
            for (int s = 0; s < 2; s++)
            begin
               // Expected values sit four bytes apart per slot
               if (val[s])
               begin
                  compare_preg("out_prs1", s, out_prs1[s*6 +: 6], rec_byte(rec, 10 + 4*s));
                  compare_preg("out_prs2", s, out_prs2[s*6 +: 6], rec_byte(rec, 11 + 4*s));
               end
               if (val[s] && we[s])
               begin
                  compare_preg("out_prd", s, out_prd[s*6 +: 6], rec_byte(rec, 12 + 4*s));
                  compare_preg("out_pfree", s, out_pfree[s*6 +: 6], rec_byte(rec, 13 + 4*s));
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: src/rn_top.sv
/*
 Two-wide register rename stage
 rn_valid is per slot; a group is taken when any slot is valid and rn_ready is high
 Renamed group appears one cycle after accept, out_prd and out_pfree only mean
 something where that slot writes a destination
*/
`default_nettype none
`include "rn_macros.svh"

module rn_top
(
   input  wire                                          clk,
   input  wire                                          arst_n,
   // Front end
   input  wire rn_reg_pkg::slot_mask_t                  rn_valid,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     rn_lrs1,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     rn_lrs2,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     rn_lrd,
   input  wire rn_reg_pkg::slot_mask_t                  rn_lrd_we,
   output logic                                         rn_ready,
   // Reorder buffer
   input  wire rn_reg_pkg::slot_mask_t                  commit_we,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     commit_lrd,
   input  wire rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]     commit_prd,
   input  wire rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]     commit_pfree,
   input  wire                                          rollback,
   // Scheduler
   output logic                                         out_valid,
   output rn_reg_pkg::slot_mask_t                       out_slot_valid,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          out_prs1,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          out_prs2,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          out_prd,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          out_pfree,
   input  wire [1:0]                                    sch_credit_ret
);
   logic                                     accept;
   logic                                     enough;
   // Invalid slots never allocate
   rn_reg_pkg::slot_mask_t                   slot_we;
   rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]      fl_prd;
   rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]      prs1;
   rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]      prs2;
   rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]      pfree;

   assign slot_we = rn_lrd_we & rn_valid;

   rn_credit_ctrl u_credit (
      .clk        (clk),
      .arst_n     (arst_n),
      .rn_valid   (|rn_valid),
      .enough     (enough),
      .rollback   (rollback),
      .credit_ret (sch_credit_ret),
      .accept     (accept),
      .rn_ready   (rn_ready)
   );

   rn_free_list u_free_list (
      .clk        (clk),
      .arst_n     (arst_n),
      .alloc      (accept),
      .alloc_mask (slot_we),
      .push_we    (commit_we),
      .push_preg  (commit_pfree),
      .rollback   (rollback),
      .head_preg  (fl_prd),
      .enough     (enough)
   );

   rn_rat u_rat (
      .clk        (clk),
      .arst_n     (arst_n),
      .we         (accept),
      .rollback   (rollback),
      .lrs1       (rn_lrs1),
      .lrs2       (rn_lrs2),
      .lrd        (rn_lrd),
      .lrd_we     (slot_we),
      .fl_prd     (fl_prd),
      .commit_we  (commit_we),
      .commit_lrd (commit_lrd),
      .commit_prd (commit_prd),
      .prs1       (prs1),
      .prs2       (prs2),
      .pfree      (pfree)
   );

   // Valids, one pulse per accepted group
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         out_valid      <= 1'b0;
         out_slot_valid <= '0;
      end
      else
      begin
         out_valid      <= accept;
         out_slot_valid <= accept ? rn_valid : '0;
      end
   end

   // Renamed payload, held between groups
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         out_prs1  <= prs1;
         out_prs2  <= prs2;
         out_prd   <= fl_prd;
         out_pfree <= pfree;
      end
   end

endmodule

`default_nettype wire

// File: src/rn_credit_ctrl.sv
/*
 Credit counter toward the scheduler and the group-accept decision
 Each group costs a full group of credits; returns show in rn_ready a cycle later
 The scheduler never returns more than it was given
*/
`default_nettype none
`include "rn_macros.svh"

module rn_credit_ctrl
(
   input  wire          clk,
   input  wire          arst_n,
   input  wire          rn_valid,
   input  wire          enough,
   input  wire          rollback,
   input  wire [1:0]    credit_ret,
   output logic         accept,
   output logic         rn_ready
);
   // Credits spent per group, independent of slot valids
   localparam rn_flow_pkg::credit_t GROUP_COST = rn_flow_pkg::credit_t'(`RN_GROUP_W);

   rn_flow_pkg::credit_t credit_q;
   rn_flow_pkg::credit_t spend;
   // Set one cycle after reset, keeps ready low while in reset
   logic                 live_q;

   assign rn_ready = live_q && (credit_q >= GROUP_COST) && enough && !rollback;
   assign accept   = rn_valid && rn_ready;
   assign spend    = accept ? GROUP_COST : '0;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         credit_q <= rn_flow_pkg::credit_t'(`RN_SCH_CREDITS);
         live_q   <= 1'b0;
      end
      else
      begin
         live_q   <= 1'b1;
         credit_q <= credit_q - spend + rn_flow_pkg::credit_t'(credit_ret);
      end
   end

endmodule

`default_nettype wire

// File: src/rn_free_list.sv
/*
 Ring of free physical registers, full with 32..63 after reset
 Commit pushes freed registers and moves the committed read pointer by the same count
 Rollback moves the read pointer back to the committed one
 The caller keeps alloc low during rollback
*/
`default_nettype none
`include "rn_macros.svh"

module rn_free_list
(
   input  wire                                          clk,
   input  wire                                          arst_n,
   input  wire                                          alloc,
   input  wire rn_reg_pkg::slot_mask_t                  alloc_mask,
   input  wire rn_reg_pkg::slot_mask_t                  push_we,
   input  wire rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]     push_preg,
   input  wire                                          rollback,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          head_preg,
   output logic                                         enough
);
   localparam int DEPTH = `RN_FL_DEPTH;

   rn_reg_pkg::preg_t    ring_q [DEPTH];
   rn_flow_pkg::fl_ptr_t rd_q;
   rn_flow_pkg::fl_ptr_t wr_q;
   rn_flow_pkg::fl_ptr_t cmt_q;
   rn_flow_pkg::fl_ptr_t rd_plus1;
   rn_flow_pkg::fl_ptr_t wr_slot1;
   rn_flow_pkg::fl_ptr_t cmt_nxt;
   rn_flow_pkg::fl_ptr_t occ;
   logic [1:0]           alloc_cnt;
   logic [1:0]           push_cnt;

   function automatic logic [1:0] mask_count(input rn_reg_pkg::slot_mask_t m);
      logic [1:0] n;
      n = '0;
      for (int s = 0; s < `RN_GROUP_W; s++)
      begin
         n = n + 2'(m[s]);
      end
      return n;
   endfunction

   assign alloc_cnt = mask_count(alloc_mask);
   assign push_cnt  = mask_count(push_we);

   // Wrap bit makes full and empty distinct
   assign occ    = wr_q - rd_q;
   assign enough = (occ >= rn_flow_pkg::fl_ptr_t'(alloc_cnt));

   // Slot 1 takes the second entry only behind an allocating slot 0
   assign rd_plus1     = rd_q + rn_flow_pkg::fl_ptr_t'(1);
   assign head_preg[0] = ring_q[rd_q[`RN_FL_AW-1:0]];
   assign head_preg[1] = alloc_mask[0] ? ring_q[rd_plus1[`RN_FL_AW-1:0]]
                                       : ring_q[rd_q[`RN_FL_AW-1:0]];

   // Pushes pack the same way
   assign wr_slot1 = wr_q + rn_flow_pkg::fl_ptr_t'(push_we[0]);
   assign cmt_nxt  = cmt_q + rn_flow_pkg::fl_ptr_t'(push_cnt);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         // Registers above the logical range start out free
         for (int i = 0; i < DEPTH; i++)
         begin
            ring_q[i] <= rn_reg_pkg::preg_t'(`RN_LREG_NUM + i);
         end
         rd_q  <= '0;
         cmt_q <= '0;
         wr_q  <= rn_flow_pkg::fl_ptr_t'(DEPTH);
      end
      else
      begin
         if (push_we[0])
         begin
            ring_q[wr_q[`RN_FL_AW-1:0]] <= push_preg[0];
         end
         if (push_we[1])
         begin
            ring_q[wr_slot1[`RN_FL_AW-1:0]] <= push_preg[1];
         end
         wr_q  <= wr_q + rn_flow_pkg::fl_ptr_t'(push_cnt);
         cmt_q <= cmt_nxt;
         // Same-cycle commit counts before the restore
         if (rollback)
         begin
            rd_q <= cmt_nxt;
         end
         else if (alloc)
         begin
            rd_q <= rd_q + rn_flow_pkg::fl_ptr_t'(alloc_cnt);
         end
      end
   end

endmodule

`default_nettype wire

// File: src/rn_rat.sv
/*
 Speculative and architectural register alias tables
 Both tables reset to identity; rollback copies the architectural table
 Slot 1 lookups bypass slot 0's new destination; the caller masks lrd_we with slot valid
 we must be low in a rollback cycle
*/
`default_nettype none
`include "rn_macros.svh"

module rn_rat
(
   input  wire                                          clk,
   input  wire                                          arst_n,
   input  wire                                          we,
   input  wire                                          rollback,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     lrs1,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     lrs2,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     lrd,
   input  wire rn_reg_pkg::slot_mask_t                  lrd_we,
   // New destinations from the free list
   input  wire rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]     fl_prd,
   // Reorder buffer commit
   input  wire rn_reg_pkg::slot_mask_t                  commit_we,
   input  wire rn_reg_pkg::lreg_t [`RN_GROUP_W-1:0]     commit_lrd,
   input  wire rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]     commit_prd,
   // Renamed sources and old destination mapping
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          prs1,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          prs2,
   output rn_reg_pkg::preg_t [`RN_GROUP_W-1:0]          pfree
);
   localparam int NUM_LREG = `RN_LREG_NUM;

   rn_reg_pkg::preg_t spec_q   [NUM_LREG];
   rn_reg_pkg::preg_t arch_q   [NUM_LREG];
   rn_reg_pkg::preg_t arch_nxt [NUM_LREG];

   // Commit writes, later slot wins on the same register
   always_comb
   begin
      arch_nxt = arch_q;
      for (int s = 0; s < `RN_GROUP_W; s++)
      begin
         if (commit_we[s])
         begin
            arch_nxt[commit_lrd[s]] = commit_prd[s];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < NUM_LREG; i++)
         begin
            arch_q[i] <= rn_reg_pkg::preg_t'(i);
         end
      end
      else
      begin
         arch_q <= arch_nxt;
      end
   end

   // Speculative table
   // Rollback sees the same-cycle commit through arch_nxt
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < NUM_LREG; i++)
         begin
            spec_q[i] <= rn_reg_pkg::preg_t'(i);
         end
      end
      else if (rollback)
      begin
         spec_q <= arch_nxt;
      end
      else if (we)
      begin
         // Loop order gives slot 1 priority on a WAW pair
         for (int s = 0; s < `RN_GROUP_W; s++)
         begin
            if (lrd_we[s])
            begin
               spec_q[lrd[s]] <= fl_prd[s];
            end
         end
      end
   end

   // Table lookups
   always_comb
   begin
      for (int s = 0; s < `RN_GROUP_W; s++)
      begin
         prs1[s]  = spec_q[lrs1[s]];
         prs2[s]  = spec_q[lrs2[s]];
         pfree[s] = spec_q[lrd[s]];
      end
      // RAW inside the group, sources of slot 1 read slot 0's new register
      if (lrd_we[0] && (lrs1[1] == lrd[0]))
      begin
         prs1[1] = fl_prd[0];
      end
      if (lrd_we[0] && (lrs2[1] == lrd[0]))
      begin
         prs2[1] = fl_prd[0];
      end
      // WAW inside the group, slot 1 frees what slot 0 just allocated
      if (lrd_we[0] && lrd_we[1] && (lrd[1] == lrd[0]))
      begin
         pfree[1] = fl_prd[0];
      end
   end

endmodule

`default_nettype wire

// File: src/rn_flow_pkg.sv
/*
 Flow-control types: scheduler credits and free-list pointers
 credit_t must hold RN_SCH_CREDITS plus one cycle of returns
*/
`default_nettype none
`include "rn_macros.svh"

package rn_flow_pkg;

   // Credit count toward the scheduler, 0 to 8
   typedef logic [3:0] credit_t;

   // Ring pointer, MSB is the wrap bit
   typedef logic [`RN_FL_AW:0] fl_ptr_t;

endpackage

`default_nettype wire

// File: src/rn_reg_pkg.sv
/*
 Register number types of the rename stage
 Multi-slot ports pack these with slot 0 in the low bits
*/
`default_nettype none
`include "rn_macros.svh"

package rn_reg_pkg;

   // Logical register number
   typedef logic [`RN_REG_AW-1:0] lreg_t;

   // Physical register number
   typedef logic [`RN_PRF_AW-1:0] preg_t;

   // One bit per group slot
   typedef logic [`RN_GROUP_W-1:0] slot_mask_t;

endpackage

`default_nettype wire

// File: src/rn_macros.svh
/*
 Widths and depths of the two-wide rename stage
 The group width is fixed at two; the RAT bypass only covers slot 1 against slot 0
 The free-list depth must equal physical minus logical registers
*/
`ifndef RN_MACROS_SVH
`define RN_MACROS_SVH

// Logical and physical register number widths
`define RN_REG_AW 5
`define RN_PRF_AW 6
// Number of logical registers, also the first physical register in the free list
`define RN_LREG_NUM 32

// Slots per rename group
`define RN_GROUP_W 2

// Free-list ring, index width without the wrap bit
`define RN_FL_DEPTH 32
`define RN_FL_AW 5

// Scheduler entries after reset
`define RN_SCH_CREDITS 8

`endif
